/* common/sdram_addr_pkg.sv */
package sdram_addr_pkg;

  // ----------------------------------------
  // Port address layout
  // ----------------------------------------
  // [25:12] row, [11:9] bank, [8:0] column
  localparam int ADDR_W = 26;

  localparam int ROW_W   = 14;
  localparam int ROW_LSB = 12;

  localparam int BANK_W   = 3;
  localparam int BANK_LSB = 9;

  localparam int COL_W = 9;

  // Row plus bank, starting at BANK_LSB
  localparam int PAGE_W = 17;

  // ----------------------------------------
  // Data path
  // ----------------------------------------
  localparam int DATA_W = 32;
  localparam int MASK_W = 4;  // One bit per 16-bit half, two per beat

  // All-bank precharge, A10 set
  localparam logic [ROW_W-1:0] PRCH_ALL_ADDR = 14'h0400;

endpackage

/* common/sdram_cmd_pkg.sv */
package sdram_cmd_pkg;

  // ----------------------------------------
  // Command encoding, {ras_n, cas_n, we_n}
  // ----------------------------------------
  typedef enum logic [2:0] {
    MRST = 3'b000,  // Mode register set
    ARSR = 3'b001,  // Auto refresh
    PRCH = 3'b010,  // Row close
    ACTV = 3'b011,  // Row open
    WRTE = 3'b100,
    READ = 3'b101,
    BTRM = 3'b110,  // Burst terminate
    NOOP = 3'b111
  } sdram_cmd_e;

  // ----------------------------------------
  // Timing
  // ----------------------------------------
  localparam logic [2:0] ACTV_TIMEOUT = 3'd4;  // ACTV to PRCH minimum

  // Recovery counter load values, by the command just issued
  localparam logic [3:0] RECOVER_ARSR = 4'd3;
  localparam logic [3:0] RECOVER_ACTV = 4'd12;
  localparam logic [3:0] RECOVER_RW   = 4'd11;
  localparam logic [3:0] RECOVER_IDLE = 4'd14;

  // Issue windows of the recovery counter
  localparam logic [3:0] ISSUE_AT_A   = 4'd13;
  localparam logic [3:0] ISSUE_AT_B   = 4'd14;
  localparam logic [3:0] ISSUE_LATE_A = 4'd14;  // Write recovery before PRCH
  localparam logic [3:0] ISSUE_LATE_B = 4'd15;

  localparam int WRITE_LATENCY = 2;  // WRTE to dq_oe

endpackage

/* hdl/dq_sequencer.sv */
`timescale 1ns/1ns

module dq_sequencer (
  input  logic                              INPUT_CLK,
  input  logic                              RST,
  input  logic                              write_slot,
  input  logic [sdram_addr_pkg::DATA_W-1:0] dq_in,
  output logic                              dq_oe,
  output logic                              dqs_oe,
  output logic [sdram_addr_pkg::DATA_W-1:0] data_r
);

  // Strobe preamble one cycle ahead of the data
  assign dqs_oe = write_slot || dq_oe;

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      dq_oe <= 1'b0;
    else
      dq_oe <= write_slot;
  end

  // Read capture, every cycle
  always_ff @(posedge INPUT_CLK)
  begin
    data_r <= dq_in;
  end

endmodule

/* hdl/sdram_ctrl_top.sv */
`timescale 1ns/1ns

module sdram_ctrl_top (
  input  logic                              INPUT_CLK,
  input  logic                              RST,
  input  logic                              refresh_strobe,
  input  logic                              rand_req,
  input  logic                              rand_we,
  input  logic [sdram_addr_pkg::ADDR_W-1:0] rand_addr,
  input  logic                              bulk_req,
  input  logic                              bulk_we,
  input  logic [sdram_addr_pkg::ADDR_W-1:0] bulk_addr,
  input  logic [sdram_addr_pkg::MASK_W-1:0] we_mask,
  input  logic [sdram_addr_pkg::DATA_W-1:0] data_w,
  input  logic [sdram_addr_pkg::DATA_W-1:0] dq_in,
  output sdram_cmd_pkg::sdram_cmd_e         cmd,
  output logic [sdram_addr_pkg::ROW_W-1:0]  addr,
  output logic [sdram_addr_pkg::BANK_W-1:0] bank,
  output logic                              grant_rand,
  output logic                              grant_bulk,
  output logic [sdram_addr_pkg::DATA_W-1:0] dq_out,
  output logic                              dq_oe,
  output logic                              dqs_oe,
  output logic [1:0]                        dm,
  output logic [sdram_addr_pkg::DATA_W-1:0] data_r
);

  logic                              req_rand_q;
  logic                              req_bulk_q;
  logic                              we_sel;
  logic                              sel_bulk;
  logic                              rand_hit;
  logic                              bulk_hit;
  logic                              any_hit;
  logic [sdram_addr_pkg::ADDR_W-1:0] sel_addr;
  logic                              page_open;
  logic [sdram_addr_pkg::PAGE_W-1:0] open_page;
  logic                              refresh_due;
  logic                              cmd_update;
  logic                              after_write;
  logic                              may_issue;
  logic                              actv_done;
  logic [sdram_addr_pkg::MASK_W-1:0] wr_mask;
  logic                              write_slot;

  // ----------------------------------------
  // Scheduler
  // ----------------------------------------
  request_latch u_request_latch (
    .INPUT_CLK   (INPUT_CLK),
    .RST         (RST),
    .rand_req    (rand_req),
    .rand_we     (rand_we),
    .rand_addr   (rand_addr),
    .bulk_req    (bulk_req),
    .bulk_we     (bulk_we),
    .bulk_addr   (bulk_addr),
    .page_open   (page_open),
    .open_page   (open_page),
    .refresh_due (refresh_due),
    .req_rand_q  (req_rand_q),
    .req_bulk_q  (req_bulk_q),
    .we_sel      (we_sel),
    .sel_bulk    (sel_bulk),
    .rand_hit    (rand_hit),
    .bulk_hit    (bulk_hit),
    .any_hit     (any_hit),
    .sel_addr    (sel_addr)
  );

  bank_timer u_bank_timer (
    .INPUT_CLK   (INPUT_CLK),
    .RST         (RST),
    .cmd_q       (cmd),
    .cmd_update  (cmd_update),
    .after_write (after_write),
    .may_issue   (may_issue),
    .actv_done   (actv_done)
  );

  command_scheduler u_command_scheduler (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .req_rand_q     (req_rand_q),
    .req_bulk_q     (req_bulk_q),
    .we_sel         (we_sel),
    .sel_bulk       (sel_bulk),
    .rand_hit       (rand_hit),
    .bulk_hit       (bulk_hit),
    .any_hit        (any_hit),
    .sel_addr       (sel_addr),
    .we_mask        (we_mask),
    .may_issue      (may_issue),
    .actv_done      (actv_done),
    .cmd            (cmd),
    .addr           (addr),
    .bank           (bank),
    .grant_rand     (grant_rand),
    .grant_bulk     (grant_bulk),
    .wr_mask        (wr_mask),
    .page_open      (page_open),
    .open_page      (open_page),
    .refresh_due    (refresh_due),
    .cmd_update     (cmd_update),
    .after_write    (after_write)
  );

  // ----------------------------------------
  // Data side
  // ----------------------------------------
  write_data_pipe u_write_data_pipe (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .cmd        (cmd),
    .data_w     (data_w),
    .we_mask    (wr_mask),
    .dq_out     (dq_out),
    .dm         (dm),
    .write_slot (write_slot)
  );

  dq_sequencer u_dq_sequencer (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .write_slot (write_slot),
    .dq_in      (dq_in),
    .dq_oe      (dq_oe),
    .dqs_oe     (dqs_oe),
    .data_r     (data_r)
  );

endmodule

/* hdl/write_data_pipe.sv */
`timescale 1ns/1ns

module write_data_pipe (
  input  logic                              INPUT_CLK,
  input  logic                              RST,
  input  sdram_cmd_pkg::sdram_cmd_e         cmd,
  input  logic [sdram_addr_pkg::DATA_W-1:0] data_w,
  input  logic [sdram_addr_pkg::MASK_W-1:0] we_mask,
  output logic [sdram_addr_pkg::DATA_W-1:0] dq_out,
  output logic [1:0]                        dm,
  output logic                              write_slot
);

  logic [sdram_addr_pkg::DATA_W-1:0]        data_hold;
  logic [sdram_addr_pkg::DATA_W-1:0]        data_s1;
  logic [sdram_addr_pkg::MASK_W-1:0]        mask_s1;
  logic [sdram_cmd_pkg::WRITE_LATENCY-1:0]  wr_pipe;
  logic                                     wr_now;

  assign wr_now     = (cmd == sdram_cmd_pkg::WRTE);
  assign write_slot = wr_pipe[sdram_cmd_pkg::WRITE_LATENCY-2];  // Cycle before the bus slot

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      wr_pipe <= '0;
    else
      wr_pipe <= {wr_pipe[sdram_cmd_pkg::WRITE_LATENCY-2:0], wr_now};
  end

  // ----------------------------------------
  // Data and mask delay line
  // ----------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    data_hold <= data_w;  // Value seen at the issue edge
    if (wr_now)
    begin
      data_s1 <= data_hold;
      mask_s1 <= we_mask;
    end
    if (write_slot)
    begin
      dq_out <= data_s1;
      dm     <= ~mask_s1[sdram_addr_pkg::MASK_W-1 -: 2];  // Upper pair first
    end
    else if (wr_pipe[sdram_cmd_pkg::WRITE_LATENCY-1])
      dm <= ~mask_s1[1:0];
  end

endmodule

/* list.f */
common/sdram_cmd_pkg.sv
common/sdram_addr_pkg.sv
scheduler/request_latch.sv
scheduler/bank_timer.sv
scheduler/command_scheduler.sv
hdl/write_data_pipe.sv
hdl/dq_sequencer.sv
hdl/sdram_ctrl_top.sv
test/tb_sdram_ctrl.sv

/* scheduler/bank_timer.sv */
`timescale 1ns/1ns

module bank_timer (
  input  logic                       INPUT_CLK,
  input  logic                       RST,
  input  sdram_cmd_pkg::sdram_cmd_e  cmd_q,
  input  logic                       cmd_update,
  input  logic                       after_write,
  output logic                       may_issue,
  output logic                       actv_done
);

  logic [$bits(sdram_cmd_pkg::RECOVER_IDLE)-1:0] counter;
  logic [$bits(sdram_cmd_pkg::ACTV_TIMEOUT)-1:0] actv_cnt;
  logic                                          ready_q;
  logic                                          extra_pass;
  logic                                          in_norm;
  logic                                          in_late;
  logic                                          window;

  assign in_norm = (counter == sdram_cmd_pkg::ISSUE_AT_A) ||
                   (counter == sdram_cmd_pkg::ISSUE_AT_B);
  assign in_late = (counter == sdram_cmd_pkg::ISSUE_LATE_A) ||
                   (counter == sdram_cmd_pkg::ISSUE_LATE_B);

  // No window on the first lap after a refresh
  assign window = !extra_pass && (after_write ? in_late : in_norm);

  assign may_issue = ready_q && !cmd_update;
  assign actv_done = (actv_cnt == sdram_cmd_pkg::ACTV_TIMEOUT);

  // ----------------------------------------
  // Recovery counter
  // ----------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      counter    <= '1;
      ready_q    <= 1'b0;
      extra_pass <= 1'b1;  // Full lap out of reset
    end
    else if (cmd_update)
    begin
      ready_q <= 1'b0;
      case (cmd_q)
        sdram_cmd_pkg::ARSR:
        begin
          counter    <= sdram_cmd_pkg::RECOVER_ARSR;
          extra_pass <= 1'b1;
        end
        sdram_cmd_pkg::ACTV: counter <= sdram_cmd_pkg::RECOVER_ACTV;
        sdram_cmd_pkg::NOOP: counter <= sdram_cmd_pkg::RECOVER_IDLE;  // Retry slot
        default:             counter <= sdram_cmd_pkg::RECOVER_RW;
      endcase
    end
    else
    begin
      ready_q <= window;
      if (!ready_q)
        counter <= counter + 1'b1;  // Parked once ready
      if (counter == '0)
        extra_pass <= 1'b0;
    end
  end

  // ACTV to PRCH timeout
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      actv_cnt <= sdram_cmd_pkg::ACTV_TIMEOUT;
    else if (cmd_update && (cmd_q == sdram_cmd_pkg::ACTV))
      actv_cnt <= '0;
    else if (!actv_done)
      actv_cnt <= actv_cnt + 1'b1;
  end

endmodule

/* scheduler/command_scheduler.sv */
`timescale 1ns/1ns

module command_scheduler (
  input  logic                              INPUT_CLK,
  input  logic                              RST,
  input  logic                              refresh_strobe,
  input  logic                              req_rand_q,
  input  logic                              req_bulk_q,
  input  logic                              we_sel,
  input  logic                              sel_bulk,
  input  logic                              rand_hit,
  input  logic                              bulk_hit,
  input  logic                              any_hit,
  input  logic [sdram_addr_pkg::ADDR_W-1:0] sel_addr,
  input  logic [sdram_addr_pkg::MASK_W-1:0] we_mask,
  input  logic                              may_issue,
  input  logic                              actv_done,
  output sdram_cmd_pkg::sdram_cmd_e         cmd,
  output logic [sdram_addr_pkg::ROW_W-1:0]  addr,
  output logic [sdram_addr_pkg::BANK_W-1:0] bank,
  output logic                              grant_rand,
  output logic                              grant_bulk,
  output logic [sdram_addr_pkg::MASK_W-1:0] wr_mask,
  output logic                              page_open,
  output logic [sdram_addr_pkg::PAGE_W-1:0] open_page,
  output logic                              refresh_due,
  output logic                              cmd_update,
  output logic                              after_write
);

  localparam int COL_PAD = sdram_addr_pkg::ROW_W - sdram_addr_pkg::COL_W - 1;

  sdram_cmd_pkg::sdram_cmd_e        next_cmd;
  logic [sdram_addr_pkg::ROW_W-1:0] next_addr;
  logic                             want;
  logic                             issue;
  logic                             last_write;
  logic                             refresh_ack;

  assign want  = req_rand_q || req_bulk_q || refresh_due;
  assign issue = may_issue && want;

  // Closing a page right after a write takes the late window
  assign after_write = page_open && last_write && !any_hit;

  // ----------------------------------------
  // Command and address choice
  // ----------------------------------------
  always_comb
  begin
    if (any_hit)
      next_cmd = we_sel ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ;
    else if (page_open)
      next_cmd = actv_done ? sdram_cmd_pkg::PRCH : sdram_cmd_pkg::NOOP;  // Wait out tRAS
    else if (refresh_due)
      next_cmd = sdram_cmd_pkg::ARSR;
    else
      next_cmd = sdram_cmd_pkg::ACTV;
  end

  always_comb
  begin
    if (any_hit)
      next_addr = {{COL_PAD{1'b0}}, sel_addr[sdram_addr_pkg::COL_W-1:0], 1'b0};
    else if (page_open)
      next_addr = sdram_addr_pkg::PRCH_ALL_ADDR;
    else
      next_addr = sel_addr[sdram_addr_pkg::ROW_LSB +: sdram_addr_pkg::ROW_W];
  end

  // ----------------------------------------
  // Issue, grants, page and refresh state
  // ----------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      cmd         <= sdram_cmd_pkg::NOOP;
      cmd_update  <= 1'b0;
      grant_rand  <= 1'b0;
      grant_bulk  <= 1'b0;
      page_open   <= 1'b0;
      last_write  <= 1'b0;
      refresh_ack <= refresh_strobe;
      refresh_due <= 1'b0;
    end
    else
    begin
      cmd_update  <= issue;
      refresh_due <= refresh_strobe ^ refresh_ack;
      if (issue)
      begin
        cmd        <= next_cmd;
        grant_rand <= rand_hit && !sel_bulk;
        grant_bulk <= bulk_hit && sel_bulk;
        case (next_cmd)
          sdram_cmd_pkg::ACTV: page_open <= 1'b1;
          sdram_cmd_pkg::PRCH: page_open <= 1'b0;
          sdram_cmd_pkg::ARSR: refresh_ack <= refresh_strobe;
          default: ;
        endcase
        if (next_cmd != sdram_cmd_pkg::NOOP)
          last_write <= (next_cmd == sdram_cmd_pkg::WRTE);
      end
      else
      begin
        cmd        <= sdram_cmd_pkg::NOOP;  // Single-cycle commands
        grant_rand <= 1'b0;
        grant_bulk <= 1'b0;
      end
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (issue)
    begin
      addr    <= next_addr;
      wr_mask <= we_mask;
      if (next_cmd == sdram_cmd_pkg::ACTV)
      begin
        open_page <= sel_addr[sdram_addr_pkg::BANK_LSB +: sdram_addr_pkg::PAGE_W];
        bank      <= sel_addr[sdram_addr_pkg::BANK_LSB +: sdram_addr_pkg::BANK_W];
      end
    end
  end

endmodule

/* scheduler/request_latch.sv */
`timescale 1ns/1ns

module request_latch (
  input  logic                              INPUT_CLK,
  input  logic                              RST,
  input  logic                              rand_req,
  input  logic                              rand_we,
  input  logic [sdram_addr_pkg::ADDR_W-1:0] rand_addr,
  input  logic                              bulk_req,
  input  logic                              bulk_we,
  input  logic [sdram_addr_pkg::ADDR_W-1:0] bulk_addr,
  input  logic                              page_open,
  input  logic [sdram_addr_pkg::PAGE_W-1:0] open_page,
  input  logic                              refresh_due,
  output logic                              req_rand_q,
  output logic                              req_bulk_q,
  output logic                              we_sel,
  output logic                              sel_bulk,
  output logic                              rand_hit,
  output logic                              bulk_hit,
  output logic                              any_hit,
  output logic [sdram_addr_pkg::ADDR_W-1:0] sel_addr
);

  logic                              rand_we_q;
  logic                              bulk_we_q;
  logic [sdram_addr_pkg::ADDR_W-1:0] rand_addr_q;
  logic [sdram_addr_pkg::ADDR_W-1:0] bulk_addr_q;
  logic                              rand_match;
  logic                              bulk_match;

  // Page compare on the live port, sampled together with the request
  assign rand_match = rand_req && page_open && !refresh_due &&
                      (rand_addr[sdram_addr_pkg::BANK_LSB +: sdram_addr_pkg::PAGE_W] ==
                       open_page);
  assign bulk_match = bulk_req && page_open && !refresh_due &&
                      (bulk_addr[sdram_addr_pkg::BANK_LSB +: sdram_addr_pkg::PAGE_W] ==
                       open_page);

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      req_rand_q <= 1'b0;
      req_bulk_q <= 1'b0;
      rand_hit   <= 1'b0;
      bulk_hit   <= 1'b0;
      any_hit    <= 1'b0;
    end
    else
    begin
      req_rand_q <= rand_req;
      req_bulk_q <= bulk_req;
      rand_hit   <= rand_match;
      bulk_hit   <= bulk_match;
      any_hit    <= bulk_req ? bulk_match : rand_match;  // Hit of the chosen port
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    rand_we_q   <= rand_we;
    bulk_we_q   <= bulk_we;
    rand_addr_q <= rand_addr;
    bulk_addr_q <= bulk_addr;
  end

  // Bulk wins whenever it asks
  assign sel_bulk = req_bulk_q;
  assign we_sel   = sel_bulk ? bulk_we_q : (req_rand_q && rand_we_q);
  assign sel_addr = sel_bulk ? bulk_addr_q : rand_addr_q;

endmodule

/* test/tb_sdram_ctrl.sv */
`timescale 1ns/1ns

module tb_sdram_ctrl;

  localparam int NROWS   = 8;
  localparam int TIMEOUT = 300;  // Cycles per wait

  logic        INPUT_CLK;
  logic        RST;
  logic        refresh_strobe;
  logic        rand_req;
  logic        rand_we;
  logic [25:0] rand_addr;
  logic        bulk_req;
  logic        bulk_we;
  logic [25:0] bulk_addr;
  logic [3:0]  we_mask;
  logic [31:0] data_w;
  logic [31:0] dq_in;
  sdram_cmd_pkg::sdram_cmd_e cmd;
  logic [13:0] addr;
  logic [2:0]  bank;
  logic        grant_rand;
  logic        grant_bulk;
  logic [31:0] dq_out;
  logic        dq_oe;
  logic        dqs_oe;
  logic [1:0]  dm;
  logic [31:0] data_r;

  // Stimulus table with port 0 random, 1 bulk and 2 both
  int          t_port [NROWS];
  bit          t_we   [NROWS];
  int          t_row  [NROWS];
  int          t_bank [NROWS];
  int          t_col  [NROWS];
  int          t_col2 [NROWS];  // Random port column when both request
  logic [3:0]  t_mask [NROWS];
  bit          t_refr [NROWS];
  logic [31:0] t_data [NROWS];

  // Expected and observed commands
  logic [2:0]  exp_cmd [$];
  int          exp_addr [$];  // -1 skips the compare
  int          exp_bank [$];
  logic [2:0]  obs_cmd [$];
  int          obs_addr [$];
  int          obs_bank [$];

  // Pending bus writes
  int          wq_cyc [$];
  logic [31:0] wq_data [$];
  logic [3:0]  wq_mask [$];

  logic [31:0] lcg_state;
  logic [2:0]  prev_cmd;
  int          cyc;
  int          errors;
  int          checks;
  bit          timed_out;
  bit          model_open;
  int          model_row;
  int          model_bank;
  int          i;

  sdram_ctrl_top dut (.*);

  always #20 INPUT_CLK = ~INPUT_CLK;

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function logic [25:0] make_addr(int row, int bnk, int col);
    return {row[13:0], bnk[2:0], col[8:0]};
  endfunction

  task check_val(input string name, input logic [31:0] got, input logic [31:0] expv);
    checks++;
    if (got !== expv)
    begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expv);
    end
  endtask

  task set_row(input int n, input int p, input bit we, input int row, input int bnk,
               input int col, input int col2, input logic [3:0] mask, input bit refr);
    t_port[n] = p;
    t_we[n]   = we;
    t_row[n]  = row;
    t_bank[n] = bnk;
    t_col[n]  = col;
    t_col2[n] = col2;
    t_mask[n] = mask;
    t_refr[n] = refr;
    t_data[n] = next_rand();
  endtask

  task expect_cmd(input logic [2:0] c, input int a, input int b);
    exp_cmd.push_back(c);
    exp_addr.push_back(a);
    exp_bank.push_back(b);
  endtask

  // Model of the open page
  task plan_access(input int row, input int bnk, input int col, input bit we);
    if (!(model_open && model_row == row && model_bank == bnk))
    begin
      if (model_open)
        expect_cmd(sdram_cmd_pkg::PRCH, 'h400, -1);
      expect_cmd(sdram_cmd_pkg::ACTV, row, bnk);
      model_open = 1;
      model_row  = row;
      model_bank = bnk;
    end
    expect_cmd(we ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ, col << 1, bnk);
  endtask

  task plan_refresh();
    if (model_open)
      expect_cmd(sdram_cmd_pkg::PRCH, 'h400, -1);
    expect_cmd(sdram_cmd_pkg::ARSR, -1, -1);
    model_open = 0;
  endtask

  // Returns on the rising edge after the grant
  task wait_grant(input bit bulk_port, input logic [2:0] want);
    int  n;
    bit  seen;
    n    = 0;
    seen = 0;
    while (!seen && !timed_out)
    begin
      @(negedge INPUT_CLK);
      if (bulk_port ? grant_bulk : grant_rand)
      begin
        seen = 1;
        check_val(bulk_port ? "cmd at grant_bulk" : "cmd at grant_rand", cmd, want);
      end
      else if (bulk_port && grant_rand)
      begin
        errors++;
        $display("Random port was granted ahead of the bulk port at %0t", $time);
      end
      n++;
      if (!seen && n >= TIMEOUT)
      begin
        timed_out = 1;
        errors++;
        $display("Timed out waiting for a grant on the %s port", bulk_port ? "bulk" : "random");
      end
    end
    @(posedge INPUT_CLK);
  endtask

  task wait_refresh();
    int  n;
    bit  seen;
    n    = 0;
    seen = 0;
    while (!seen && !timed_out)
    begin
      @(negedge INPUT_CLK);
      seen = (cmd == sdram_cmd_pkg::ARSR);
      n++;
      if (!seen && n >= TIMEOUT)
      begin
        timed_out = 1;
        errors++;
        $display("Timed out waiting for the refresh command");
      end
    end
    @(posedge INPUT_CLK);
  endtask

  task compare_commands(input int row_n);
    int k;
    if (obs_cmd.size() != exp_cmd.size())
    begin
      errors++;
      $display("Row %0d expected %0d commands but saw %0d", row_n, exp_cmd.size(),
               obs_cmd.size());
    end
    for (k = 0; k < exp_cmd.size() && k < obs_cmd.size(); k++)
    begin
      check_val("cmd", obs_cmd[k], exp_cmd[k]);
      if (exp_addr[k] >= 0)
        check_val("addr", obs_addr[k], exp_addr[k]);
      if (exp_bank[k] >= 0)
        check_val("bank", obs_bank[k], exp_bank[k]);
    end
    exp_cmd.delete();
    exp_addr.delete();
    exp_bank.delete();
    obs_cmd.delete();
    obs_addr.delete();
    obs_bank.delete();
  endtask

  // ----------------------------------------
  // Memory-side monitor
  // ----------------------------------------
  always @(negedge INPUT_CLK)
  begin
    if (!RST)
    begin
      if (cmd != sdram_cmd_pkg::NOOP)
      begin
        obs_cmd.push_back(cmd);
        obs_addr.push_back(addr);
        obs_bank.push_back(bank);
        if (prev_cmd != sdram_cmd_pkg::NOOP)
        begin
          errors++;
          $display("Two commands back to back at %0t", $time);
        end
        if (cmd == sdram_cmd_pkg::WRTE)
        begin
          wq_cyc.push_back(cyc + sdram_cmd_pkg::WRITE_LATENCY);
          wq_data.push_back(data_w);  // Held by the requester until the grant
          wq_mask.push_back(we_mask);
        end
      end
      if ((grant_rand || grant_bulk) && cmd != sdram_cmd_pkg::READ &&
          cmd != sdram_cmd_pkg::WRTE)
      begin
        errors++;
        $display("Grant without an access command at %0t", $time);
      end
      check_val("dq_oe", dq_oe, wq_cyc.size() > 0 && wq_cyc[0] == cyc);
      check_val("dqs_oe", dqs_oe, wq_cyc.size() > 0 &&
                (wq_cyc[0] == cyc || wq_cyc[0] == cyc + 1));
      if (wq_cyc.size() > 0 && wq_cyc[0] == cyc)
      begin
        check_val("dq_out", dq_out, wq_data[0]);
        check_val("dm", dm, 2'(~wq_mask[0][3:2]));
        void'(wq_cyc.pop_front());
        void'(wq_data.pop_front());
        void'(wq_mask.pop_front());
      end
    end
    prev_cmd = cmd;
    cyc++;
  end

  initial
  begin
    INPUT_CLK      = 0;
    RST            = 1;
    refresh_strobe = 0;
    rand_req       = 0;
    rand_we        = 0;
    rand_addr      = '0;
    bulk_req       = 0;
    bulk_we        = 0;
    bulk_addr      = '0;
    we_mask        = '0;
    data_w         = '0;
    dq_in          = '0;
    lcg_state      = 32'd1231;
    prev_cmd       = sdram_cmd_pkg::NOOP;
    cyc            = 0;
    errors         = 0;
    checks         = 0;
    timed_out      = 0;
    model_open     = 0;

    set_row(0, 0, 0, 'h0123, 2, 'h011, 0, 4'hF, 0);  // Closed page
    set_row(1, 0, 1, 'h0123, 2, 'h045, 0, 4'hB, 0);  // Hit
    set_row(2, 0, 0, 'h0200, 2, 'h003, 0, 4'hF, 0);  // Miss
    set_row(3, 0, 0, 'h0200, 2, 'h005, 0, 4'hF, 1);
    set_row(4, 1, 1, 'h0200, 2, 'h007, 0, 4'h7, 0);
    set_row(5, 2, 1, 'h3FFF, 5, 'h1FF, 'h010, 4'hD, 0);  // Both ports
    set_row(6, 1, 1, 'h0001, 0, 'h000, 0, 4'hE, 1);
    set_row(7, 0, 1, 'h0001, 0, 'h0A0, 0, 4'h3, 0);

    repeat (4) @(posedge INPUT_CLK);
    #2 RST = 0;

    // Idle after reset
    repeat (3)
    begin
      @(negedge INPUT_CLK);
      check_val("cmd", cmd, sdram_cmd_pkg::NOOP);
      check_val("grant_rand", grant_rand, 0);
      check_val("grant_bulk", grant_bulk, 0);
      check_val("dq_oe", dq_oe, 0);
      check_val("dqs_oe", dqs_oe, 0);
    end
    @(posedge INPUT_CLK);
    #2;

    for (i = 0; i < NROWS && !timed_out; i++)
    begin
      if (t_refr[i])
      begin
        plan_refresh();
        refresh_strobe = ~refresh_strobe;
        wait_refresh();
        #2;
      end
      data_w  = t_data[i];
      we_mask = t_mask[i];
      if (t_port[i] == 0)
      begin
        rand_req  = 1;
        rand_we   = t_we[i];
        rand_addr = make_addr(t_row[i], t_bank[i], t_col[i]);
        plan_access(t_row[i], t_bank[i], t_col[i], t_we[i]);
        wait_grant(0, t_we[i] ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ);
        #2 rand_req = 0;
      end
      else
      begin
        bulk_req  = 1;
        bulk_we   = t_we[i];
        bulk_addr = make_addr(t_row[i], t_bank[i], t_col[i]);
        if (t_port[i] == 2)
        begin
          rand_req  = 1;
          rand_we   = 0;
          rand_addr = make_addr(t_row[i], t_bank[i], t_col2[i]);
        end
        plan_access(t_row[i], t_bank[i], t_col[i], t_we[i]);
        wait_grant(1, t_we[i] ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ);
        #2 bulk_req = 0;
        if (t_port[i] == 2)
        begin
          plan_access(t_row[i], t_bank[i], t_col2[i], 0);
          wait_grant(0, sdram_cmd_pkg::READ);
          #2 rand_req = 0;
        end
      end
      compare_commands(i);
    end

    // Read capture
    dq_in = next_rand();
    @(posedge INPUT_CLK);
    @(negedge INPUT_CLK);
    check_val("data_r", data_r, dq_in);

    repeat (4) @(posedge INPUT_CLK);
    if (wq_cyc.size() != 0)
    begin
      errors++;
      $display("Write data never reached the bus");
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
